//--- cache_subsys.f
+incdir+logic
logic/cache_pkg.sv
logic/cache_front_end.sv
logic/cache_memory.sv
logic/cache_control.sv
logic/cache_top.sv
verification/backend_memory_model.sv
verification/cache_properties.sv
verification/cache_tb.sv

//--- logic/cache_control.sv
`timescale 1ns/1ps

module cache_control (
   input  logic                  clk_i,
   input  logic                  reset,
   input  logic                  ctrl_start,
   input  logic                  req_we,
   input  cache_pkg::ctrl_addr_t req_ctrl_addr,
   input  logic                  hit_event,
   input  logic                  miss_event,
   input  logic                  write_event,
   output logic                  ctrl_ack,
   output cache_pkg::word_t      ctrl_rdata,
   output logic                  invalidate
);

   localparam int NCOUNT = 3;
   localparam cache_pkg::ctrl_addr_t INVAL_OFFSET = 2'd3;

   // offsets 0..2 are hits, misses, writes
   cache_pkg::count_t counts [NCOUNT];
   logic [NCOUNT-1:0] events;
   logic              wr_access;

   assign events    = {write_event, miss_event, hit_event};
   assign wr_access = ctrl_start & req_we;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         ctrl_ack   <= 1'b0;
         invalidate <= 1'b0;
         for (int i = 0; i < NCOUNT; i++) begin
            counts[i] <= '0;
         end
      end else begin
         ctrl_ack   <= ctrl_start;
         invalidate <= wr_access && (req_ctrl_addr == INVAL_OFFSET);
         for (int i = 0; i < NCOUNT; i++) begin
            if (wr_access && (req_ctrl_addr == cache_pkg::ctrl_addr_t'(i))) begin
               counts[i] <= '0;
            end else if (events[i] && (counts[i] != '1)) begin
               // saturate at all ones
               counts[i] <= counts[i] + 1'b1;
            end
         end
      end
   end

   // read-back, valid with ctrl_ack
   always_ff @(posedge clk_i) begin
      if (ctrl_start) begin
         if (req_ctrl_addr == INVAL_OFFSET) begin
            ctrl_rdata <= '0;
         end else begin
            ctrl_rdata <= cache_pkg::word_t'(counts[req_ctrl_addr]);
         end
      end
   end

endmodule

//--- logic/cache_front_end.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_front_end (
   input  logic                   clk_i,
   input  logic                   reset,
   input  logic                   req,
   input  logic                   we,
   input  logic [`CACHE_ADDR_W:0] addr,
   input  cache_pkg::word_t       wdata,
   input  cache_pkg::strb_t       wstrb,
   input  logic                   data_ack,
   input  cache_pkg::word_t       data_rdata,
   input  logic                   ctrl_ack,
   input  cache_pkg::word_t       ctrl_rdata,
   output logic                   ack,
   output cache_pkg::word_t       rdata,
   output logic                   data_start,
   output logic                   ctrl_start,
   output logic                   req_we,
   output cache_pkg::addr_t       req_addr,
   output cache_pkg::word_t       req_wdata,
   output cache_pkg::strb_t       req_wstrb,
   output cache_pkg::ctrl_addr_t  req_ctrl_addr
);

   logic busy;
   logic accept;
   logic sel_ctrl;

   // a held req is taken only once
   assign accept   = req & ~busy;
   assign sel_ctrl = addr[`CACHE_ADDR_W];

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         busy       <= 1'b0;
         data_start <= 1'b0;
         ctrl_start <= 1'b0;
      end else begin
         data_start <= accept & ~sel_ctrl;
         ctrl_start <= accept & sel_ctrl;
         if (accept) begin
            busy <= 1'b1;
         end else if (ack) begin
            busy <= 1'b0;
         end
      end
   end

   // stored copy of the request, stable while busy
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_we    <= we;
         req_addr  <= addr[`CACHE_ADDR_W-1:0];
         req_wdata <= wdata;
         req_wstrb <= wstrb;
      end
   end

   assign req_ctrl_addr = req_addr[`CACHE_CTRL_ADDR_W-1:0];

   // only one block is active, so the acks never overlap
   assign ack   = data_ack | ctrl_ack;
   assign rdata = ctrl_ack ? ctrl_rdata : data_rdata;

endmodule

//--- logic/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// word address into the cacheable space
`define CACHE_ADDR_W 12
`define CACHE_DATA_W 32
`define CACHE_STRB_W 4

// 16 one-word lines
`define CACHE_INDEX_W 4
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W)

// control register offset and counter size
`define CACHE_CTRL_ADDR_W 2
`define CACHE_COUNT_W 16

`endif

//--- logic/cache_memory.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_memory (
   input  logic              clk_i,
   input  logic              reset,
   input  logic              data_start,
   input  logic              req_we,
   input  cache_pkg::addr_t  req_addr,
   input  cache_pkg::word_t  req_wdata,
   input  cache_pkg::strb_t  req_wstrb,
   input  logic              invalidate,
   input  logic              mem_ack,
   input  cache_pkg::word_t  mem_rdata,
   output logic              data_ack,
   output cache_pkg::word_t  data_rdata,
   output logic              hit_event,
   output logic              miss_event,
   output logic              write_event,
   output logic              mem_req,
   output logic              mem_we,
   output cache_pkg::addr_t  mem_addr,
   output cache_pkg::word_t  mem_wdata,
   output cache_pkg::strb_t  mem_wstrb
);

   localparam int LINES = 2 ** `CACHE_INDEX_W;

   cache_pkg::mem_state_t state;
   cache_pkg::mem_state_t state_nxt;

   // line storage
   logic [LINES-1:0]  valid;
   cache_pkg::tag_t   tag_mem  [LINES];
   cache_pkg::word_t  data_mem [LINES];

   cache_pkg::index_t index;
   cache_pkg::tag_t   tag;
   logic              hit;
   logic              lookup;
   logic              mem_done;
   logic              done;

   assign index = req_addr[`CACHE_INDEX_W-1:0];
   assign tag   = req_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];

   assign lookup = (state == cache_pkg::LOOKUP);
   assign hit    = valid[index] && (tag_mem[index] == tag);

   // back-end transfer finishing this cycle
   assign mem_done = mem_req & mem_ack;

   always_comb begin
      state_nxt = state;
      case (state)
         cache_pkg::IDLE: begin
            if (data_start) begin
               state_nxt = cache_pkg::LOOKUP;
            end
         end
         cache_pkg::LOOKUP: begin
            if (req_we) begin
               state_nxt = cache_pkg::WRITE_THRU;
            end else if (hit) begin
               state_nxt = cache_pkg::IDLE;
            end else begin
               state_nxt = cache_pkg::FILL;
            end
         end
         cache_pkg::FILL,
         cache_pkg::WRITE_THRU: begin
            if (mem_ack) begin
               state_nxt = cache_pkg::IDLE;
            end
         end
         default: state_nxt = cache_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state <= cache_pkg::IDLE;
         done  <= 1'b0;
         valid <= '0;
      end else begin
         state <= state_nxt;
         // answer comes one cycle after the back end
         done  <= mem_done;
         if (invalidate) begin
            valid <= '0;
         end else if ((state == cache_pkg::FILL) && mem_ack) begin
            valid[index] <= 1'b1;
         end
      end
   end

   // tag and data arrays
   always_ff @(posedge clk_i) begin
      if ((state == cache_pkg::FILL) && mem_ack) begin
         tag_mem[index]  <= tag;
         data_mem[index] <= mem_rdata;
      end else if (lookup && req_we && hit) begin
         // write hit, merge under the strobes
         for (int b = 0; b < `CACHE_STRB_W; b++) begin
            if (req_wstrb[b]) begin
               data_mem[index][8*b +: 8] <= req_wdata[8*b +: 8];
            end
         end
      end
   end

   // read hit answers straight from the array,
   // a fill has already written the line when done is high
   assign data_ack   = (lookup && !req_we && hit) || done;
   assign data_rdata = data_mem[index];

   assign hit_event   = lookup && !req_we && hit;
   assign miss_event  = lookup && !req_we && !hit;
   assign write_event = lookup && req_we;

   // back-end port, held until mem_ack
   assign mem_req   = (state == cache_pkg::FILL) || (state == cache_pkg::WRITE_THRU);
   assign mem_we    = (state == cache_pkg::WRITE_THRU);
   assign mem_addr  = req_addr;
   assign mem_wdata = req_wdata;
   assign mem_wstrb = mem_we ? req_wstrb : '0;

endmodule

//--- logic/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

   // word address, data and byte lanes
   typedef logic [`CACHE_ADDR_W-1:0] addr_t;
   typedef logic [`CACHE_DATA_W-1:0] word_t;
   typedef logic [`CACHE_STRB_W-1:0] strb_t;

   // address split for the line arrays
   typedef logic [`CACHE_INDEX_W-1:0] index_t;
   typedef logic [`CACHE_TAG_W-1:0]   tag_t;

   // register block
   typedef logic [`CACHE_CTRL_ADDR_W-1:0] ctrl_addr_t;
   typedef logic [`CACHE_COUNT_W-1:0]     count_t;

   // cache memory FSM
   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      FILL,
      WRITE_THRU
   } mem_state_t;

endpackage

//--- logic/cache_top.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_top (
   input  logic                   clk_i,
   input  logic                   reset,
   // requester port
   input  logic                   req,
   input  logic                   we,
   input  logic [`CACHE_ADDR_W:0] addr,
   input  cache_pkg::word_t       wdata,
   input  cache_pkg::strb_t       wstrb,
   output logic                   ack,
   output cache_pkg::word_t       rdata,
   // back-end port
   output logic                   mem_req,
   output logic                   mem_we,
   output cache_pkg::addr_t       mem_addr,
   output cache_pkg::word_t       mem_wdata,
   output cache_pkg::strb_t       mem_wstrb,
   input  cache_pkg::word_t       mem_rdata,
   input  logic                   mem_ack
);

   logic                  data_start;
   logic                  ctrl_start;
   logic                  req_we;
   cache_pkg::addr_t      req_addr;
   cache_pkg::word_t      req_wdata;
   cache_pkg::strb_t      req_wstrb;
   cache_pkg::ctrl_addr_t req_ctrl_addr;
   logic                  data_ack;
   cache_pkg::word_t      data_rdata;
   logic                  ctrl_ack;
   cache_pkg::word_t      ctrl_rdata;

   // event lines between memory and control
   logic hit_event;
   logic miss_event;
   logic write_event;
   logic invalidate;

   cache_front_end front_end (
      .clk_i         (clk_i),
      .reset         (reset),
      .req           (req),
      .we            (we),
      .addr          (addr),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .data_ack      (data_ack),
      .data_rdata    (data_rdata),
      .ctrl_ack      (ctrl_ack),
      .ctrl_rdata    (ctrl_rdata),
      .ack           (ack),
      .rdata         (rdata),
      .data_start    (data_start),
      .ctrl_start    (ctrl_start),
      .req_we        (req_we),
      .req_addr      (req_addr),
      .req_wdata     (req_wdata),
      .req_wstrb     (req_wstrb),
      .req_ctrl_addr (req_ctrl_addr)
   );

   cache_memory memory (
      .clk_i       (clk_i),
      .reset       (reset),
      .data_start  (data_start),
      .req_we      (req_we),
      .req_addr    (req_addr),
      .req_wdata   (req_wdata),
      .req_wstrb   (req_wstrb),
      .invalidate  (invalidate),
      .mem_ack     (mem_ack),
      .mem_rdata   (mem_rdata),
      .data_ack    (data_ack),
      .data_rdata  (data_rdata),
      .hit_event   (hit_event),
      .miss_event  (miss_event),
      .write_event (write_event),
      .mem_req     (mem_req),
      .mem_we      (mem_we),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .mem_wstrb   (mem_wstrb)
   );

   cache_control control (
      .clk_i         (clk_i),
      .reset         (reset),
      .ctrl_start    (ctrl_start),
      .req_we        (req_we),
      .req_ctrl_addr (req_ctrl_addr),
      .hit_event     (hit_event),
      .miss_event    (miss_event),
      .write_event   (write_event),
      .ctrl_ack      (ctrl_ack),
      .ctrl_rdata    (ctrl_rdata),
      .invalidate    (invalidate)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module cache_tb -f cache_subsys.f \
   --Mdir obj_dir -o cache_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   exit 1
fi
exit 0

//--- verification/backend_memory_model.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module backend_memory_model (
   input  logic             clk_i,
   input  logic             reset,
   input  logic             mem_req,
   input  logic             mem_we,
   input  cache_pkg::addr_t mem_addr,
   input  cache_pkg::word_t mem_wdata,
   input  cache_pkg::strb_t mem_wstrb,
   output cache_pkg::word_t mem_rdata,
   output logic             mem_ack
);

   localparam int WORDS = 2 ** `CACHE_ADDR_W;

   cache_pkg::word_t storage [WORDS];
   integer           seed = 81323;
   logic             busy;
   logic [1:0]       delay;

   // every word differs from its neighbours in all address bits
   initial begin
      for (int i = 0; i < WORDS; i++) begin
         storage[i] = {12'(i) ^ 12'ha5c, 8'h3c, 12'(i)};
      end
   end

   // ack 1 to 4 cycles after mem_req is first seen
   always @(posedge clk_i or posedge reset) begin
      if (reset) begin
         busy      <= 1'b0;
         delay     <= 2'd0;
         mem_ack   <= 1'b0;
         mem_rdata <= '0;
      end else begin
         mem_ack <= 1'b0;
         if (!busy) begin
            if (mem_req && !mem_ack) begin
               busy  <= 1'b1;
               delay <= 2'($random(seed));
            end
         end else if (delay != 2'd0) begin
            delay <= delay - 2'd1;
         end else begin
            busy      <= 1'b0;
            mem_ack   <= 1'b1;
            mem_rdata <= storage[mem_addr];
            for (int b = 0; b < `CACHE_STRB_W; b++) begin
               if (mem_we && mem_wstrb[b]) begin
                  storage[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
               end
            end
         end
      end
   end

endmodule

//--- verification/cache_properties.sv
`timescale 1ns/1ps

module cache_properties (
   input logic             clk_i,
   input logic             reset,
   input logic             ack,
   input logic             start_a,
   input logic             start_b,
   input logic             mem_req,
   input logic             mem_ack,
   input cache_pkg::addr_t mem_addr
);

   // a response is a single-cycle pulse
   ack_single: assert property (@(posedge clk_i) disable iff (reset) ack |=> !ack)
      else $error("ack high for more than one cycle");

   // back-end request held with a fixed address until mem_ack
   mem_hold: assert property (@(posedge clk_i) disable iff (reset)
      mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
      else $error("mem_req or mem_addr changed before mem_ack");

   // data and control paths never start together or while an answer is on ack
   start_excl: assert property (@(posedge clk_i) disable iff (reset)
      !(start_a && start_b) && !((start_a || start_b) && ack))
      else $error("start pulse overlaps the other start or an ack");

endmodule

//--- verification/cache_tb.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb;

   localparam int TIMEOUT = 50;
   localparam int SLOW    = -1;
   localparam int WORDS   = 2 ** `CACHE_ADDR_W;
   localparam int LINES   = 2 ** `CACHE_INDEX_W;

   logic                   clk_i;
   logic                   reset;
   logic                   req;
   logic                   we;
   logic [`CACHE_ADDR_W:0] addr;
   cache_pkg::word_t       wdata;
   cache_pkg::strb_t       wstrb;
   logic                   ack;
   cache_pkg::word_t       rdata;
   logic                   mem_req;
   logic                   mem_we;
   cache_pkg::addr_t       mem_addr;
   cache_pkg::word_t       mem_wdata;
   cache_pkg::strb_t       mem_wstrb;
   cache_pkg::word_t       mem_rdata;
   logic                   mem_ack;

   // mirror of the back end, the line tags and the counters
   cache_pkg::word_t mirror [WORDS];
   logic [LINES-1:0] line_valid = '0;
   cache_pkg::tag_t  line_tag [LINES];
   int               exp_hits = 0;
   int               exp_misses = 0;
   int               exp_writes = 0;

   // expected responses in issue order
   cache_pkg::word_t exp_data_q [$];
   bit               exp_check_q [$];
   int               exp_lat_q [$];

   integer seed = 81323;
   int     checks = 0;
   int     mismatches = 0;
   int     errors = 0;
   int     wait_cycles = 0;

   cache_top UUT (.*);

   backend_memory_model backend (.*);

   bind cache_front_end cache_properties front_end_checks (
      .clk_i(clk_i), .reset(reset), .ack(ack), .start_a(data_start), .start_b(ctrl_start),
      .mem_req(1'b0), .mem_ack(1'b0), .mem_addr('0));
   bind cache_memory cache_properties memory_checks (
      .clk_i(clk_i), .reset(reset), .ack(data_ack), .start_a(data_start), .start_b(1'b0),
      .mem_req(mem_req), .mem_ack(mem_ack), .mem_addr(mem_addr));

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_w,
         input cache_pkg::word_t new_w, input cache_pkg::strb_t strb);
      cache_pkg::word_t res;
      res = old_w;
      for (int b = 0; b < `CACHE_STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   // reference for one data access that returns 1 on a read hit
   function automatic bit predict_access(input bit is_write, input cache_pkg::addr_t a,
         input cache_pkg::word_t d, input cache_pkg::strb_t s);
      cache_pkg::index_t idx;
      cache_pkg::tag_t   tg;
      bit                hit;
      idx = a[`CACHE_INDEX_W-1:0];
      tg  = a[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
      hit = line_valid[idx] && (line_tag[idx] == tg);
      if (is_write) begin
         // write-through without allocation on a miss
         mirror[a] = merge_bytes(mirror[a], d, s);
         exp_writes++;
      end else if (hit) begin
         exp_hits++;
      end else begin
         line_valid[idx] = 1'b1;
         line_tag[idx]   = tg;
         exp_misses++;
      end
      return hit;
   endfunction

   task automatic finish_run();
      $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, errors);
      if (mismatches == 0 && errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   endtask

   // one requester transfer held until ack
   task automatic transfer(input bit is_write, input bit sel_ctrl, input cache_pkg::addr_t a,
         input cache_pkg::word_t d, input cache_pkg::strb_t s);
      int cycles;
      bit done;
      cycles = 0;
      done   = 1'b0;
      @(posedge clk_i);
      req   <= 1'b1;
      we    <= is_write;
      addr  <= {sel_ctrl, a};
      wdata <= d;
      wstrb <= s;
      while (!done && cycles < TIMEOUT) begin
         @(negedge clk_i);
         cycles++;
         done = ack;
      end
      if (!done) begin
         $display("error at %0t: no ack for address %h within %0d cycles", $time, a, TIMEOUT);
         errors++;
         finish_run();
      end else begin
         @(posedge clk_i);
         req <= 1'b0;
      end
   endtask

   task automatic data_read(input cache_pkg::addr_t a);
      bit hit;
      hit = predict_access(1'b0, a, '0, '0);
      exp_data_q.push_back(mirror[a]);
      exp_check_q.push_back(1'b1);
      exp_lat_q.push_back(hit ? 2 : SLOW);
      transfer(1'b0, 1'b0, a, '0, '0);
   endtask

   task automatic data_write(input cache_pkg::addr_t a, input cache_pkg::word_t d,
         input cache_pkg::strb_t s);
      void'(predict_access(1'b1, a, d, s));
      exp_data_q.push_back('0);
      exp_check_q.push_back(1'b0);
      exp_lat_q.push_back(SLOW);
      transfer(1'b1, 1'b0, a, d, s);
   endtask

   task automatic ctrl_access(input bit is_write, input cache_pkg::ctrl_addr_t off);
      cache_pkg::word_t v;
      case (off)
         2'd0: v = cache_pkg::word_t'(exp_hits);
         2'd1: v = cache_pkg::word_t'(exp_misses);
         2'd2: v = cache_pkg::word_t'(exp_writes);
         default: v = '0;
      endcase
      exp_data_q.push_back(v);
      exp_check_q.push_back(!is_write);
      exp_lat_q.push_back(2);
      if (is_write) begin
         case (off)
            2'd0: exp_hits = 0;
            2'd1: exp_misses = 0;
            2'd2: exp_writes = 0;
            default: line_valid = '0;
         endcase
      end
      transfer(is_write, 1'b1, cache_pkg::addr_t'(off), '0, '0);
   endtask

   // compare every ack against the oldest expected response
   always @(negedge clk_i) begin : compare
      cache_pkg::word_t exp_d;
      bit               exp_c;
      int               exp_l;
      if (!reset && req) begin
         wait_cycles++;
      end
      if (!reset && ack) begin
         if (exp_data_q.size() == 0) begin
            $display("error at %0t: ack without an outstanding request", $time);
            errors++;
         end else begin
            exp_d = exp_data_q.pop_front();
            exp_c = exp_check_q.pop_front();
            exp_l = exp_lat_q.pop_front();
            checks++;
            if (exp_c && rdata !== exp_d) begin
               $display("mismatch at %0t: rdata %h, expected %h", $time, rdata, exp_d);
               mismatches++;
            end
            // latency counts from the first cycle req is sampled
            if (exp_l == SLOW && wait_cycles - 1 <= 2) begin
               $display("mismatch at %0t: ack after %0d cycles, expected a back-end access",
                  $time, wait_cycles - 1);
               mismatches++;
            end else if (exp_l != SLOW && wait_cycles - 1 != exp_l) begin
               $display("mismatch at %0t: ack after %0d cycles, expected %0d",
                  $time, wait_cycles - 1, exp_l);
               mismatches++;
            end
         end
         wait_cycles = 0;
      end
   end

   initial begin : stimulus
      cache_pkg::addr_t a;
      cache_pkg::word_t d;
      cache_pkg::strb_t s;
      req   = 1'b0;
      we    = 1'b0;
      addr  = '0;
      wdata = '0;
      wstrb = '0;
      reset = 1'b1;
      repeat (4) @(posedge clk_i);
      reset <= 1'b0;
      for (int i = 0; i < WORDS; i++) begin
         mirror[i] = backend.storage[i];
      end

      // miss after reset then a hit on the same word
      data_read(12'h123);
      ctrl_access(1'b0, 2'd0);
      ctrl_access(1'b0, 2'd1);
      data_read(12'h123);
      ctrl_access(1'b0, 2'd0);

      // random traffic over four tags per line
      for (int n = 0; n < 80; n++) begin
         a = {2'($random(seed)), 6'h15, 4'($random(seed))};
         if ($random(seed) & 1) begin
            d = $random(seed);
            s = 4'($random(seed));
            data_write(a, d, s);
         end else begin
            data_read(a);
         end
      end

      // tags competing for line 9
      for (int t = 0; t < 4; t++) begin
         data_read({8'(t * 37), 4'h9});
         data_read({8'(t * 37), 4'h9});
      end
      data_read({8'd0, 4'h9});
      for (int r = 0; r < 3; r++) begin
         ctrl_access(1'b0, 2'(r));
      end

      // counter clear and invalidate
      for (int r = 0; r < 3; r++) begin
         ctrl_access(1'b1, 2'(r));
         ctrl_access(1'b0, 2'(r));
      end
      data_read(12'h123);
      data_read(12'h123);
      ctrl_access(1'b1, 2'd3);
      data_read(12'h123);
      ctrl_access(1'b0, 2'd0);
      ctrl_access(1'b0, 2'd1);
      ctrl_access(1'b0, 2'd3);

      for (int i = 0; i < WORDS; i++) begin
         if (backend.storage[i] !== mirror[i]) begin
            $display("mismatch at %0t: back end word %h is %h, expected %h",
               $time, i, backend.storage[i], mirror[i]);
            mismatches++;
         end
      end
      finish_run();
   end

endmodule
